//--- dcache_pkg.sv
package dcache_pkg;

  // address layout is index, tag, beat number, byte offset from the top down
  localparam int addr_w = 36;
  localparam int index_w = 8;
  localparam int tag_w = 22;
  localparam int beat_w = 128;
  localparam int beats_per_line = 4;
  localparam int word_w = 32;
  localparam int node_id_w = 5;

  // line address with the beat number and byte offset removed
  typedef logic [index_w+tag_w-1:0] line_addr_t;

  // one beat taken either as a whole or as four processor words
  typedef union packed {
    logic [beat_w-1:0] raw;
    logic [beat_w/word_w-1:0][word_w-1:0] words;
  } beat_u;

  typedef beat_u [beats_per_line-1:0] line_t;

  typedef struct packed {
    logic rd;
    logic wr;
    logic [addr_w-1:0] addr;
    logic [word_w-1:0] wdata;
  } cpu_req_t;

  typedef enum logic [2:0] {
    pkt_empty     = 3'b000,
    pkt_writeback = 3'b001,
    pkt_fill_req  = 3'b011,
    pkt_ack       = 3'b101,
    pkt_data      = 3'b110
  } pkt_type_e;

  // contents of the single ring slot
  typedef struct packed {
    pkt_type_e ptype;
    logic [node_id_w-1:0] id;
    logic [addr_w-1:0] addr;
    logic [beat_w-1:0] data;
  } ring_pkt_t;

endpackage

//--- cache_array.sv
`timescale 1ns/1ps

module cache_array import dcache_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic [addr_w-1:0] lookup_addr,
  input  logic [1:0] rd_beat_sel,
  output logic hit,
  output logic dirty,
  output logic [tag_w-1:0] victim_tag,
  output beat_u lookup_beat,
  input  logic store_en,
  input  beat_u store_beat,
  input  logic install_en,
  input  line_t install_line
);

  localparam int sets = 1 << index_w;

  logic [sets-1:0] valid_q;
  logic [sets-1:0] dirty_q;
  logic [tag_w-1:0] tag_mem [sets];
  line_t data_mem [sets];
  logic [index_w-1:0] index;
  logic [tag_w-1:0] tag;

  assign index = lookup_addr[addr_w-1 -: index_w];
  assign tag = lookup_addr[addr_w-index_w-1 -: tag_w];

  // the stored tag doubles as the victim tag since the cache is direct-mapped
  assign victim_tag = tag_mem[index];
  assign hit = valid_q[index] & (tag_mem[index] == tag);
  assign dirty = valid_q[index] & dirty_q[index];

  // in idle the controller selects the requested beat, during writeback it walks the line
  assign lookup_beat = data_mem[index][rd_beat_sel];

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (install_en) begin
      valid_q[index] <= 1'b1;
      dirty_q[index] <= 1'b0;
    end else if (store_en) begin
      dirty_q[index] <= 1'b1;
    end
  end

  // an install replaces the whole line, a store only the selected beat
  always_ff @(posedge clk) begin
    if (install_en) begin
      tag_mem[index] <= tag;
      data_mem[index] <= install_line;
    end else if (store_en) begin
      data_mem[index][rd_beat_sel] <= store_beat;
    end
  end

endmodule

//--- word_merge.sv
`timescale 1ns/1ps

module word_merge import dcache_pkg::*; (
  input  beat_u lookup_beat,
  input  logic [addr_w-1:0] addr,
  input  logic [word_w-1:0] wdata,
  output logic [word_w-1:0] rd_data,
  output beat_u merged_beat
);

  logic [1:0] word_sel;

  // address bits 3 to 2 name the word inside the beat
  assign word_sel = addr[3:2];

  // read data comes straight from the looked up beat
  assign rd_data = lookup_beat.words[word_sel];

  // the store word replaces one slot and the other three pass through unchanged
  always_comb begin
    merged_beat = lookup_beat;
    merged_beat.words[word_sel] = wdata;
  end

endmodule

//--- fill_buffer.sv
`timescale 1ns/1ps

module fill_buffer import dcache_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic capture,
  input  logic clear,
  input  ring_pkt_t reply,
  output line_t line,
  output logic full
);

  logic [beats_per_line-1:0] beat_valid;
  logic [1:0] beat_num;

  // memory may return the beats in any order, so each one lands by its own number
  assign beat_num = reply.addr[5:4];

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      beat_valid <= '0;
    end else if (clear) begin
      beat_valid <= '0;
    end else if (capture) begin
      beat_valid[beat_num] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      line[beat_num].raw <= reply.data;
    end
  end

  // high from the cycle after the last beat arrives
  assign full = &beat_valid;

endmodule

//--- miss_controller.sv
`timescale 1ns/1ps

module miss_controller import dcache_pkg::*; #(
  parameter logic [node_id_w-1:0] node_id = 5'd3
) (
  input  logic clk,
  input  logic rst,
  input  cpu_req_t req,
  input  logic hit,
  input  logic dirty,
  input  logic [tag_w-1:0] victim_tag,
  input  beat_u lookup_beat,
  input  logic fill_full,
  input  ring_pkt_t ring_in,
  output ring_pkt_t ring_out,
  output logic overwrite,
  output logic stall,
  output logic store_en,
  output logic install_en,
  output logic [1:0] rd_beat_sel,
  output logic capture,
  output logic clear
);

  typedef enum logic [2:0] {
    idle,
    writeback,
    writeback_ack,
    fill_request,
    fill_wait,
    install
  } state_e;

  state_e state;
  state_e next_state;
  logic [1:0] wb_cnt;
  logic wb_adv;
  logic req_active;
  logic slot_free;
  logic reply_mine;
  line_addr_t victim_line;
  line_addr_t req_line;

  assign req_active = req.rd | req.wr;
  assign slot_free = (ring_in.ptype == pkt_empty);
  assign reply_mine = (ring_in.id == node_id);

  // victim and request share the index, only the tag differs
  assign victim_line = {req.addr[addr_w-1 -: index_w], victim_tag};
  assign req_line = req.addr[addr_w-1 -: index_w+tag_w];

  always_comb begin
    next_state = state;
    stall = 1'b1;
    overwrite = 1'b0;
    ring_out = '0;
    store_en = 1'b0;
    install_en = 1'b0;
    capture = 1'b0;
    clear = 1'b0;
    wb_adv = 1'b0;
    rd_beat_sel = req.addr[5:4];
    case (state)
      // hits finish here in the same cycle, a miss picks the first phase
      idle: begin
        stall = req_active & ~hit;
        store_en = req.wr & hit;
        if (req_active && !hit) begin
          next_state = dirty ? writeback : fill_request;
        end
      end
      // one beat per free slot, the counter wraps back to zero after the last
      writeback: begin
        rd_beat_sel = wb_cnt;
        if (slot_free) begin
          overwrite = 1'b1;
          wb_adv = 1'b1;
          ring_out.ptype = pkt_writeback;
          ring_out.id = node_id;
          ring_out.addr = {victim_line, wb_cnt, 4'b0000};
          ring_out.data = lookup_beat.raw;
          if (wb_cnt == 2'd3) begin
            next_state = writeback_ack;
          end
        end
      end
      // releasing the ack leaves an empty packet in the slot
      writeback_ack: begin
        if (ring_in.ptype == pkt_ack && reply_mine) begin
          overwrite = 1'b1;
          next_state = fill_request;
        end
      end
      fill_request: begin
        if (slot_free) begin
          overwrite = 1'b1;
          ring_out.ptype = pkt_fill_req;
          ring_out.id = node_id;
          ring_out.addr = {req_line, 6'b000000};
          next_state = fill_wait;
        end
      end
      fill_wait: begin
        if (fill_full) begin
          next_state = install;
        end else if (ring_in.ptype == pkt_data && reply_mine) begin
          overwrite = 1'b1;
          capture = 1'b1;
        end
      end
      // the request is retried from idle and hits on the fresh line
      install: begin
        install_en = 1'b1;
        clear = 1'b1;
        next_state = idle;
      end
      default: begin
        next_state = idle;
      end
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state <= idle;
      wb_cnt <= 2'd0;
    end else begin
      state <= next_state;
      if (wb_adv) begin
        wb_cnt <= wb_cnt + 2'd1;
      end
    end
  end

endmodule

//--- dcache_top.sv
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; #(
  parameter logic [node_id_w-1:0] node_id = 5'd3
) (
  input  logic clk,
  input  logic rst,
  input  cpu_req_t req,
  output logic stall,
  output logic [word_w-1:0] rd_data,
  input  ring_pkt_t ring_in,
  output ring_pkt_t ring_out,
  output logic overwrite
);

  logic hit;
  logic dirty;
  logic [tag_w-1:0] victim_tag;
  beat_u lookup_beat;
  beat_u merged_beat;
  logic store_en;
  logic install_en;
  logic [1:0] rd_beat_sel;
  logic capture;
  logic clear;
  line_t fill_line;
  logic fill_full;

  cache_array u_cache_array (
    .clk(clk),
    .rst(rst),
    .lookup_addr(req.addr),
    .rd_beat_sel(rd_beat_sel),
    .hit(hit),
    .dirty(dirty),
    .victim_tag(victim_tag),
    .lookup_beat(lookup_beat),
    .store_en(store_en),
    .store_beat(merged_beat),
    .install_en(install_en),
    .install_line(fill_line)
  );

  word_merge u_word_merge (
    .lookup_beat(lookup_beat),
    .addr(req.addr),
    .wdata(req.wdata),
    .rd_data(rd_data),
    .merged_beat(merged_beat)
  );

  // replies are captured from the slot while the controller consumes them
  fill_buffer u_fill_buffer (
    .clk(clk),
    .rst(rst),
    .capture(capture),
    .clear(clear),
    .reply(ring_in),
    .line(fill_line),
    .full(fill_full)
  );

  miss_controller #(
    .node_id(node_id)
  ) u_miss_controller (
    .clk(clk),
    .rst(rst),
    .req(req),
    .hit(hit),
    .dirty(dirty),
    .victim_tag(victim_tag),
    .lookup_beat(lookup_beat),
    .fill_full(fill_full),
    .ring_in(ring_in),
    .ring_out(ring_out),
    .overwrite(overwrite),
    .stall(stall),
    .store_en(store_en),
    .install_en(install_en),
    .rd_beat_sel(rd_beat_sel),
    .capture(capture),
    .clear(clear)
  );

endmodule

//--- tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache import dcache_pkg::*; ();

  localparam logic [node_id_w-1:0] node_id = 5'd3;
  localparam int timeout_cycles = 2000;

  typedef struct {
    string name;
    bit wr;
    logic [addr_w-1:0] addr;
    logic [word_w-1:0] wdata;
    int exp_hit;
    int exp_wb;
    line_addr_t victim;
  } op_t;

  logic clk;
  logic rst;
  cpu_req_t req;
  logic stall;
  logic [word_w-1:0] rd_data;
  ring_pkt_t slot;
  ring_pkt_t ring_out;
  logic overwrite;

  // exp_hit is 1 for a hit, 0 for a miss and 2 when either is fine
  op_t ops[$];
  logic [word_w-1:0] ref_mem [logic [addr_w-3:0]];
  logic [beat_w-1:0] ring_mem [logic [addr_w-5:0]];
  ring_pkt_t reply_q[$];
  int reply_due[$];
  int cyc = 0;
  int sent_count = 0;
  int wb_count = 0;
  int fill_count = 0;
  line_addr_t last_wb_line = '0;

  dcache_top #(
    .node_id(node_id)
  ) uut (
    .clk(clk),
    .rst(rst),
    .req(req),
    .stall(stall),
    .rd_data(rd_data),
    .ring_in(slot),
    .ring_out(ring_out),
    .overwrite(overwrite)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // untouched memory holds a pattern built from the whole word address
  function automatic logic [word_w-1:0] init_word(logic [addr_w-1:0] addr);
    return addr[35:4] ^ {addr[3:2], 26'h0, addr[3:2], addr[3:2]};
  endfunction

  function automatic logic [word_w-1:0] ref_read(logic [addr_w-1:0] addr);
    logic [word_w-1:0] word;
    if (ref_mem.exists(addr[35:2])) begin
      word = ref_mem[addr[35:2]];
    end else begin
      word = init_word(addr);
    end
    return word;
  endfunction

  function automatic logic [beat_w-1:0] mem_beat(logic [addr_w-1:0] addr);
    logic [beat_w-1:0] beat;
    if (ring_mem.exists(addr[35:4])) begin
      beat = ring_mem[addr[35:4]];
    end else begin
      for (int k = 0; k < 4; k++) begin
        beat[k*32 +: 32] = init_word({addr[35:4], 2'(k), 2'b00});
      end
    end
    return beat;
  endfunction

  function automatic logic [addr_w-1:0] mk_addr(int index, int tag, int beat, int word);
    return {8'(index), 22'(tag), 2'(beat), 2'(word), 2'b00};
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [beat_w-1:0] exp,
                             input logic [beat_w-1:0] act);
    if (exp !== act) begin
      fail_run($sformatf("Error: %s expected %0h actual %0h", name, exp, act));
    end
  endtask

  // the data beats come back shuffled and spaced by random gaps
  task automatic queue_fill_replies(input logic [addr_w-1:0] addr);
    int order[4];
    int tmp;
    int j;
    int due;
    ring_pkt_t pkt;
    for (int k = 0; k < 4; k++) begin
      order[k] = k;
    end
    for (int k = 3; k > 0; k--) begin
      j = $urandom_range(k, 0);
      tmp = order[k];
      order[k] = order[j];
      order[j] = tmp;
    end
    due = cyc;
    for (int k = 0; k < 4; k++) begin
      due = due + 1 + $urandom_range(3, 0);
      pkt.ptype = pkt_data;
      pkt.id = node_id;
      pkt.addr = {addr[35:6], 2'(order[k]), 4'b0000};
      pkt.data = mem_beat(pkt.addr);
      reply_q.push_back(pkt);
      reply_due.push_back(due);
    end
  endtask

  task automatic record_send(input ring_pkt_t pkt);
    ring_pkt_t ack;
    sent_count++;
    check_value("send_id", 128'(node_id), 128'(pkt.id));
    case (pkt.ptype)
      pkt_writeback: begin
        check_value("writeback_beat_order", 128'(wb_count % 4), 128'(pkt.addr[5:4]));
        // all beats of one series name the same victim line
        if (wb_count % 4 != 0) begin
          check_value("writeback_line", 128'(last_wb_line), 128'(pkt.addr[35:6]));
        end
        for (int k = 0; k < 4; k++) begin
          check_value("writeback_data", 128'(ref_read({pkt.addr[35:4], 2'(k), 2'b00})),
                      128'(pkt.data[k*32 +: 32]));
        end
        ring_mem[pkt.addr[35:4]] = pkt.data;
        last_wb_line = pkt.addr[35:6];
        wb_count++;
        // one ack closes each series of four beats
        if (wb_count % 4 == 0) begin
          ack = '0;
          ack.ptype = pkt_ack;
          ack.id = node_id;
          reply_q.push_back(ack);
          reply_due.push_back(cyc + 1 + $urandom_range(5, 0));
        end
      end
      pkt_fill_req: begin
        fill_count++;
        check_value("fill_req_after_writeback", 128'(0), 128'(wb_count % 4));
        check_value("fill_req_offset", 128'(0), 128'(pkt.addr[5:0]));
        queue_fill_replies(pkt.addr);
      end
      default: begin
        fail_run("the DUT sent a packet of an unexpected type");
      end
    endcase
  endtask

  // single ring slot with memory behind it and other nodes passing traffic
  initial begin : ring_model
    ring_pkt_t seen;
    ring_pkt_t sent;
    ring_pkt_t foreign;
    logic ow;
    int foreign_left;
    slot = '0;
    foreign_left = 0;
    forever begin
      @(negedge clk);
      ow = overwrite;
      sent = ring_out;
      seen = slot;
      if (ow) begin
        if (seen.ptype == pkt_empty) begin
          record_send(sent);
        end else if (seen.id == node_id && (seen.ptype == pkt_ack || seen.ptype == pkt_data)) begin
          check_value("consume_leaves_empty", 128'(pkt_empty), 128'(sent.ptype));
        end else begin
          fail_run("overwrite rose while the slot held a packet of another node");
        end
      end
      @(posedge clk);
      #1;
      cyc++;
      if (ow) begin
        slot = sent;
      end else if (slot.id == node_id &&
                   (slot.ptype == pkt_writeback || slot.ptype == pkt_fill_req)) begin
        // memory takes the request out of the slot
        slot = '0;
      end else if (foreign_left > 0) begin
        foreign_left--;
        if (foreign_left == 0) begin
          slot = '0;
        end
      end else if (slot.ptype == pkt_empty) begin
        if (reply_q.size() > 0 && reply_due[0] <= cyc) begin
          slot = reply_q.pop_front();
          void'(reply_due.pop_front());
        end else if ($urandom_range(3, 0) == 0) begin
          case ($urandom_range(2, 0))
            0: foreign.ptype = pkt_data;
            1: foreign.ptype = pkt_ack;
            default: foreign.ptype = pkt_writeback;
          endcase
          foreign.id = 5'd9;
          foreign.addr = {4'($urandom()), $urandom()};
          foreign.data = {$urandom(), $urandom(), $urandom(), $urandom()};
          slot = foreign;
          foreign_left = 1 + $urandom_range(3, 0);
        end
      end
    end
  end

  task automatic add_op(input string name, input bit wr, input logic [addr_w-1:0] addr,
                        input logic [word_w-1:0] wdata, input int exp_hit, input int exp_wb,
                        input line_addr_t victim);
    op_t op;
    op.name = name;
    op.wr = wr;
    op.addr = addr;
    op.wdata = wdata;
    op.exp_hit = exp_hit;
    op.exp_wb = exp_wb;
    op.victim = victim;
    ops.push_back(op);
  endtask

  task automatic build_table();
    add_op("read_miss_clean", 1'b0, mk_addr(5, 1, 2, 1), '0, 0, 0, '0);
    add_op("read_hit_same_line", 1'b0, mk_addr(5, 1, 0, 3), '0, 1, 0, '0);
    add_op("write_hit", 1'b1, mk_addr(5, 1, 2, 2), 32'hdead_beef, 1, 0, '0);
    add_op("read_word0_after_write", 1'b0, mk_addr(5, 1, 2, 0), '0, 1, 0, '0);
    add_op("read_word1_after_write", 1'b0, mk_addr(5, 1, 2, 1), '0, 1, 0, '0);
    add_op("read_word2_after_write", 1'b0, mk_addr(5, 1, 2, 2), '0, 1, 0, '0);
    add_op("read_word3_after_write", 1'b0, mk_addr(5, 1, 2, 3), '0, 1, 0, '0);
    add_op("read_dirty_victim", 1'b0, mk_addr(5, 2, 1, 0), '0, 0, 4, {8'd5, 22'd1});
    add_op("read_back_written_word", 1'b0, mk_addr(5, 1, 2, 2), '0, 0, 0, '0);
    add_op("write_miss", 1'b1, mk_addr(9, 3, 3, 0), 32'h1234_5678, 0, 0, '0);
    add_op("read_after_write_miss", 1'b0, mk_addr(9, 3, 3, 0), '0, 1, 0, '0);
    // two indexes and three tags keep the lines colliding
    for (int i = 0; i < 40; i++) begin
      add_op("random_mix", 1'($urandom_range(1, 0)),
             mk_addr(($urandom_range(1, 0) == 0) ? 5 : 9, 1 + $urandom_range(2, 0),
                     $urandom_range(3, 0), $urandom_range(3, 0)),
             $urandom(), 2, -1, '0);
    end
  endtask

  task automatic run_op(input op_t op);
    int waits;
    int wb0;
    int fill0;
    logic [word_w-1:0] exp_word;
    wb0 = wb_count;
    fill0 = fill_count;
    req.rd = ~op.wr;
    req.wr = op.wr;
    req.addr = op.addr;
    req.wdata = op.wdata;
    waits = 0;
    @(negedge clk);
    while (stall) begin
      waits++;
      if (waits > timeout_cycles) begin
        fail_run($sformatf("%s timed out with stall still high", op.name));
      end
      @(negedge clk);
    end
    // the request completes at the coming edge
    if (op.wr) begin
      ref_mem[op.addr[35:2]] = op.wdata;
    end else begin
      exp_word = ref_read(op.addr);
      check_value(op.name, 128'(exp_word), 128'(rd_data));
    end
    if (op.exp_hit == 1) begin
      check_value({op.name, "_wait_cycles"}, 128'(0), 128'(waits));
      check_value({op.name, "_fill_requests"}, 128'(0), 128'(fill_count - fill0));
    end else if (op.exp_hit == 0) begin
      check_value({op.name, "_fill_requests"}, 128'(1), 128'(fill_count - fill0));
    end
    if (op.exp_wb >= 0) begin
      check_value({op.name, "_writebacks"}, 128'(op.exp_wb), 128'(wb_count - wb0));
    end
    if (op.exp_wb == 4) begin
      check_value({op.name, "_victim_line"}, 128'(op.victim), 128'(last_wb_line));
    end
    @(posedge clk);
    #1;
    req = '0;
  endtask

  initial begin : stimulus
    void'($urandom(10));
    rst = 1'b1;
    req = '0;
    build_table();
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    // with no request the controller stays quiet
    for (int i = 0; i < 6; i++) begin
      @(negedge clk);
      check_value("idle_stall", 128'(0), 128'(stall));
      check_value("idle_overwrite", 128'(0), 128'(overwrite));
    end
    check_value("idle_sent_count", 128'(0), 128'(sent_count));
    @(posedge clk);
    #1;
    for (int i = 0; i < ops.size(); i++) begin
      run_op(ops[i]);
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- compile.f
dcache_pkg.sv
cache_array.sv
word_merge.sv
fill_buffer.sv
miss_controller.sv
dcache_top.sv
tb_dcache.sv

//--- Makefile
TOP = tb_dcache

.PHONY: sim clean

sim:
	verilator --binary --timing -f compile.f --top-module $(TOP)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
